// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build tb_dla with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --assert -j 0 -f project.f --top-module tb_dla -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_dla 2>&1); echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== logic/clp_sequencer.sv ====
`timescale 1ns/1ps

module clp_sequencer import dla_pkg::*; (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic [BUS_WIDTH-1:0]  i_instr_head,
    input  logic                  i_instr_valid,
    output logic                  o_pop,
    output logic                  o_stop,
    output logic [ADDR_WIDTH-1:0] o_feature_addr,
    output logic                  o_feature_rd_en,
    input  logic [BUS_WIDTH-1:0]  i_feature_data,
    output logic [ADDR_WIDTH-1:0] o_w_addr,
    output logic                  o_w_rd_en,
    input  logic [BUS_WIDTH-1:0]  i_w_data,
    lane_bus_if.seq               bus,
    input  logic                  i_slot_free,    // drain can take a vector
    output logic                  o_done
);

    seq_state_e            state;
    opcode_e               opcode;
    logic [BUS_WIDTH-1:0]  instr_q;
    logic [CNT_WIDTH-1:0]  count;
    logic [CNT_WIDTH-1:0]  cnt;                    // reads issued so far
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [TN-1:0]         w_sel;                  // lane of the weight read in flight

    assign opcode = opcode_e'(instr_q[OPC_LSB +: OPC_WIDTH]);
    assign count  = instr_q[CNT_LSB +: CNT_WIDTH];
    assign o_pop  = (state == POP);

    // both memories share the running address
    assign o_feature_addr = rd_addr;
    assign o_w_addr       = rd_addr;

    // returning words go to the lanes as they are, strobes below mark them
    assign bus.feature_word = i_feature_data;
    assign bus.weight_word  = i_w_data;

    always_ff @(posedge clk) begin
        if (state == POP) instr_q <= i_instr_head;
    end

    //////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state             <= IDLE;
            cnt               <= '0;
            rd_addr           <= '0;
            w_sel             <= '0;
            o_feature_rd_en   <= 1'b0;
            o_w_rd_en         <= 1'b0;
            o_stop            <= 1'b0;
            o_done            <= 1'b0;
            bus.feature_valid <= 1'b0;
            bus.acc_clear     <= 1'b0;
            bus.weight_load   <= '0;
            bus.scale_strobe  <= 1'b0;
            bus.shift         <= '0;
        end else begin
            o_feature_rd_en  <= 1'b0;           // single cycle strobes
            o_w_rd_en        <= 1'b0;
            o_stop           <= 1'b0;
            bus.acc_clear    <= 1'b0;
            bus.scale_strobe <= 1'b0;
            // read valid flags, data is on the port one cycle after the enable
            bus.feature_valid <= o_feature_rd_en;
            bus.weight_load   <= o_w_rd_en ? w_sel : '0;
            if (o_feature_rd_en | o_w_rd_en) begin
                rd_addr <= rd_addr + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (i_instr_valid) state <= POP;
                end
                POP: state <= DECODE;
                DECODE: begin
                    cnt     <= '0;
                    rd_addr <= instr_q[SRC_LSB +: ADDR_WIDTH];
                    case (opcode)
                        OP_LOAD_WEIGHT: state <= LOAD_W;
                        OP_COMPUTE: begin
                            bus.acc_clear <= 1'b1;
                            bus.shift     <= instr_q[SHIFT_LSB +: SHIFT_WIDTH];
                            state         <= STREAM;
                        end
                        OP_END: begin
                            o_stop <= 1'b1;         // no more prefetch
                            state  <= HALT;
                        end
                        default: state <= IDLE;     // unknown opcode, skip it
                    endcase
                end
                LOAD_W: begin
                    if (cnt == CNT_WIDTH'(TN)) begin
                        state <= IDLE;
                    end else begin
                        o_w_rd_en <= 1'b1;
                        w_sel     <= TN'(1) << cnt;   // word k -> lane k
                        cnt       <= cnt + 1'b1;
                    end
                end
                STREAM: begin
                    if (cnt == count) begin
                        state <= DRAIN_WAIT;
                    end else begin
                        o_feature_rd_en <= 1'b1;
                        cnt             <= cnt + 1'b1;
                    end
                end
                DRAIN_WAIT: begin
                    // last word accumulated and drain empty
                    if (!o_feature_rd_en && !bus.feature_valid && i_slot_free) begin
                        bus.scale_strobe <= 1'b1;
                        state            <= SCALE;
                    end
                end
                SCALE: state <= IDLE;
                HALT: begin
                    if (i_slot_free) o_done <= 1'b1;    // last vector has left
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_strobe_slot : assert property (@(posedge clk) disable iff (i_reset)
        $rose(bus.scale_strobe) |-> i_slot_free)
        else $error("scale strobe while result drain is occupied");

endmodule

// ==== logic/dla_pkg.sv ====
package dla_pkg;

    //////////////////////////////////////////////////
    // datapath sizes
    //////////////////////////////////////////////////
    localparam int TN            = 4;   // mac lanes
    localparam int TAPS          = 8;   // elements per bus word
    localparam int FEATURE_WIDTH = 8;
    localparam int KERNEL_WIDTH  = 8;
    localparam int BUS_WIDTH     = 64;
    localparam int ADDR_WIDTH    = 16;
    localparam int ACC_WIDTH     = 32;
    localparam int RESULT_WIDTH  = 16;  // saturated lane output

    // instruction queue, one fetch credit per entry
    localparam int IFIFO_DEPTH = 4;
    localparam int IFIFO_AW    = $clog2(IFIFO_DEPTH);
    localparam int IFIFO_CW    = $clog2(IFIFO_DEPTH + 1);

    // output credits held after reset
    localparam int RESULT_CREDITS = 2;
    localparam int RESULT_CW      = $clog2(RESULT_CREDITS + 1);

    //////////////////////////////////////////////////
    // instruction word layout
    //////////////////////////////////////////////////
    localparam int OPC_LSB     = 60;    // [63:60]
    localparam int OPC_WIDTH   = 4;
    localparam int CNT_LSB     = 52;    // [59:52]
    localparam int CNT_WIDTH   = 8;
    localparam int SRC_LSB     = 36;    // [51:36], ADDR_WIDTH wide
    localparam int SHIFT_LSB   = 0;     // [3:0]
    localparam int SHIFT_WIDTH = 4;

    typedef enum logic [OPC_WIDTH-1:0] {
        OP_LOAD_WEIGHT = 4'h1,
        OP_COMPUTE     = 4'h2,
        OP_END         = 4'hf
    } opcode_e;                         // anything else is a no-op

    typedef enum logic [2:0] {
        IDLE, POP, DECODE, LOAD_W, STREAM, DRAIN_WAIT, SCALE, HALT
    } seq_state_e;

endpackage

// ==== logic/dla_top.sv ====
`timescale 1ns/1ps

module dla_top import dla_pkg::*; (
    input  logic                       clk,
    input  logic                       i_reset,
    input  logic                       i_acc_enable,
    // instruction memory
    input  logic [BUS_WIDTH-1:0]       i_instr,
    output logic [ADDR_WIDTH-1:0]      o_instr_addr,
    output logic                       o_instr_rd_en,
    // feature memory
    input  logic [BUS_WIDTH-1:0]       i_feature_data,
    output logic [ADDR_WIDTH-1:0]      o_feature_addr,
    output logic                       o_feature_rd_en,
    // weight memory
    input  logic [BUS_WIDTH-1:0]       i_w_data,
    output logic [ADDR_WIDTH-1:0]      o_w_addr,
    output logic                       o_w_rd_en,
    // results
    output logic [TN*RESULT_WIDTH-1:0] o_scaled_feature,
    output logic                       o_result_valid,
    input  logic                       i_credit_return,
    output logic                       o_done
);

    logic [BUS_WIDTH-1:0]       instr_head;
    logic                       instr_valid;
    logic                       pop;
    logic                       stop;
    logic                       slot_free;
    logic [TN*RESULT_WIDTH-1:0] lane_results;
    logic [TN-1:0]              lane_valid;

    lane_bus_if lane_bus ();

    instr_fetch u_fetch (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_start       (i_acc_enable),
        .i_stop        (stop),
        .i_pop         (pop),
        .i_instr       (i_instr),
        .o_instr_addr  (o_instr_addr),
        .o_instr_rd_en (o_instr_rd_en),
        .o_instr_head  (instr_head),
        .o_instr_valid (instr_valid)
    );

    clp_sequencer u_seq (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_instr_head    (instr_head),
        .i_instr_valid   (instr_valid),
        .o_pop           (pop),
        .o_stop          (stop),
        .o_feature_addr  (o_feature_addr),
        .o_feature_rd_en (o_feature_rd_en),
        .i_feature_data  (i_feature_data),
        .o_w_addr        (o_w_addr),
        .o_w_rd_en       (o_w_rd_en),
        .i_w_data        (i_w_data),
        .bus             (lane_bus),
        .i_slot_free     (slot_free),
        .o_done          (o_done)
    );

    //////////////////////////////////////////////////
    // mac lanes
    //////////////////////////////////////////////////
    for (genvar k = 0; k < TN; k++) begin : g_lane
        mac_lane #(.LANE_INDEX(k)) u_lane (
            .clk            (clk),
            .i_reset        (i_reset),
            .bus            (lane_bus),
            .o_result       (lane_results[k*RESULT_WIDTH +: RESULT_WIDTH]),
            .o_result_valid (lane_valid[k])
        );
    end

    result_drain u_drain (
        .clk              (clk),
        .i_reset          (i_reset),
        .i_lane_results   (lane_results),
        .i_lane_valid     (lane_valid),
        .o_scaled_feature (o_scaled_feature),
        .o_result_valid   (o_result_valid),
        .i_credit_return  (i_credit_return),
        .o_slot_free      (slot_free)
    );

endmodule

// ==== logic/instr_fetch.sv ====
`timescale 1ns/1ps

module instr_fetch import dla_pkg::*; (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_start,        // acc enable pulse
    input  logic                  i_stop,         // end opcode decoded
    input  logic                  i_pop,
    input  logic [BUS_WIDTH-1:0]  i_instr,
    output logic [ADDR_WIDTH-1:0] o_instr_addr,
    output logic                  o_instr_rd_en,
    output logic [BUS_WIDTH-1:0]  o_instr_head,
    output logic                  o_instr_valid
);

    logic                 running;
    logic                 issue;
    logic                 push;                   // memory word lands this cycle
    logic [IFIFO_CW-1:0]  credits;
    logic [IFIFO_CW-1:0]  level;
    logic [IFIFO_AW-1:0]  wr_ptr;
    logic [IFIFO_AW-1:0]  rd_ptr;
    logic [BUS_WIDTH-1:0] queue [IFIFO_DEPTH];

    // a read needs a free slot counting the ones still in flight
    assign issue = (running | i_start) & ~i_stop & (credits != '0);

    //////////////////////////////////////////////////
    // fetch address and credits
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_reset) begin
            running       <= 1'b0;
            credits       <= IFIFO_CW'(IFIFO_DEPTH);
            o_instr_rd_en <= 1'b0;
            o_instr_addr  <= '0;
            push          <= 1'b0;
        end else begin
            if (i_stop) begin
                running <= 1'b0;
            end else if (i_start) begin
                running <= 1'b1;
            end
            o_instr_rd_en <= issue;
            push          <= o_instr_rd_en;     // one cycle read latency
            if (o_instr_rd_en) begin
                o_instr_addr <= o_instr_addr + 1'b1;
            end
            credits <= credits - IFIFO_CW'(issue) + IFIFO_CW'(i_pop);
        end
    end

    //////////////////////////////////////////////////
    // circular queue
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (i_pop) rd_ptr <= rd_ptr + 1'b1;
            level <= level + IFIFO_CW'(push) - IFIFO_CW'(i_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) queue[wr_ptr] <= i_instr;
    end

    assign o_instr_head  = queue[rd_ptr];   // pointer is registered, pop shows next cycle
    assign o_instr_valid = (level != '0);

    a_credit_max : assert property (@(posedge clk) disable iff (i_reset)
        credits <= IFIFO_CW'(IFIFO_DEPTH))
        else $error("fetch credits above queue depth");

    a_no_overflow : assert property (@(posedge clk) disable iff (i_reset)
        push |-> level < IFIFO_CW'(IFIFO_DEPTH))
        else $error("instruction queue written while full");

endmodule

// ==== logic/lane_bus_if.sv ====
`timescale 1ns/1ps

// sequencer to mac lane broadcast
interface lane_bus_if import dla_pkg::*; ();

    logic [BUS_WIDTH-1:0]   feature_word;   // straight from the feature port
    logic                   feature_valid;
    logic                   acc_clear;      // start of a compute job
    logic [BUS_WIDTH-1:0]   weight_word;
    logic [TN-1:0]          weight_load;    // one-hot, bit k writes lane k
    logic                   scale_strobe;
    logic [SHIFT_WIDTH-1:0] shift;          // arithmetic right shift amount

    modport seq (
        output feature_word,
        output feature_valid,
        output acc_clear,
        output weight_word,
        output weight_load,
        output scale_strobe,
        output shift
    );

    modport lane (
        input feature_word,
        input feature_valid,
        input acc_clear,
        input weight_word,
        input weight_load,
        input scale_strobe,
        input shift
    );

endinterface

// ==== logic/mac_lane.sv ====
`timescale 1ns/1ps

module mac_lane import dla_pkg::*; #(
    parameter int LANE_INDEX = 0            // picks the weight_load bit
) (
    input  logic                    clk,
    input  logic                    i_reset,
    lane_bus_if.lane                bus,
    output logic [RESULT_WIDTH-1:0] o_result,
    output logic                    o_result_valid
);

    logic signed [KERNEL_WIDTH-1:0] weight [TAPS];
    logic signed [ACC_WIDTH-1:0]    acc;
    logic signed [ACC_WIDTH-1:0]    dot;
    logic signed [ACC_WIDTH-1:0]    scaled;
    logic                           fits;

    always_ff @(posedge clk) begin
        if (bus.weight_load[LANE_INDEX]) begin
            for (int t = 0; t < TAPS; t++) begin
                weight[t] <= bus.weight_word[t*KERNEL_WIDTH +: KERNEL_WIDTH];
            end
        end
    end

    // signed dot product of one feature word with the lane weights
    always_comb begin
        dot = '0;
        for (int t = 0; t < TAPS; t++) begin
            dot = dot + ACC_WIDTH'(
                signed'(bus.feature_word[t*FEATURE_WIDTH +: FEATURE_WIDTH]) * weight[t]);
        end
    end

    assign scaled = acc >>> bus.shift;
    // fits in 16 bits when the upper bits are all sign copies
    assign fits = (&scaled[ACC_WIDTH-1:RESULT_WIDTH-1]) |
                  ~(|scaled[ACC_WIDTH-1:RESULT_WIDTH-1]);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            acc            <= '0;
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= bus.scale_strobe;
            if (bus.acc_clear) begin
                acc <= '0;
            end else if (bus.feature_valid) begin
                acc <= acc + dot;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.scale_strobe) begin
            o_result <= fits ? scaled[RESULT_WIDTH-1:0]
                             : {scaled[ACC_WIDTH-1], {(RESULT_WIDTH-1){~scaled[ACC_WIDTH-1]}}};
        end
    end

endmodule

// ==== logic/result_drain.sv ====
`timescale 1ns/1ps

module result_drain import dla_pkg::*; (
    input  logic                       clk,
    input  logic                       i_reset,
    input  logic [TN*RESULT_WIDTH-1:0] i_lane_results,
    input  logic [TN-1:0]              i_lane_valid,
    output logic [TN*RESULT_WIDTH-1:0] o_scaled_feature,
    output logic                       o_result_valid,
    input  logic                       i_credit_return,   // one credit per pulse
    output logic                       o_slot_free
);

    logic                 full;             // holding register occupied
    logic                 capture;
    logic [RESULT_CW-1:0] credits;

    assign capture     = &i_lane_valid;
    assign o_slot_free = ~full;

    always_ff @(posedge clk) begin
        if (capture) o_scaled_feature <= i_lane_results;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            full           <= 1'b0;
            o_result_valid <= 1'b0;
            credits        <= RESULT_CW'(RESULT_CREDITS);
        end else begin
            o_result_valid <= 1'b0;
            if (capture) begin
                full <= 1'b1;
            end else if (full && credits != '0) begin
                o_result_valid <= 1'b1;     // vector leaves, slot frees
                full           <= 1'b0;
            end
            // credit spent in the valid cycle itself
            credits <= credits - RESULT_CW'(o_result_valid) + RESULT_CW'(i_credit_return);
        end
    end

    a_valid_credit : assert property (@(posedge clk) disable iff (i_reset)
        o_result_valid |-> credits != '0)
        else $error("result sent without an output credit");

    a_credit_max : assert property (@(posedge clk) disable iff (i_reset)
        credits <= RESULT_CW'(RESULT_CREDITS))
        else $error("more output credits returned than issued");

endmodule

// ==== project.f ====
+incdir+sim
logic/dla_pkg.sv
logic/lane_bus_if.sv
logic/instr_fetch.sv
logic/clp_sequencer.sv
logic/mac_lane.sv
logic/result_drain.sv
logic/dla_top.sv
sim/tb_dla.sv

// ==== sim/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// one compute job per row
typedef struct packed {
    logic       load_w;     // load-weight instruction ahead of the compute
    logic [7:0] w_src;      // first of TN weight words
    logic [7:0] f_src;      // first feature word
    logic [7:0] count;      // feature words streamed
    logic [3:0] shift;
    logic       sat;        // extreme fill, result pinned at the 16-bit limits
} job_t;

localparam int NJOBS = 8;

localparam job_t JOBS [NJOBS] = '{
    '{1'b1, 8'h00, 8'h10, 8'd4,  4'd2,  1'b0},
    '{1'b0, 8'h00, 8'h18, 8'd9,  4'd3,  1'b0},  // reuses the weights at 0x00
    '{1'b1, 8'h04, 8'h10, 8'd4,  4'd2,  1'b0},  // same features as row 0, new weights
    '{1'b1, 8'h20, 8'h60, 8'd8,  4'd0,  1'b1},
    '{1'b0, 8'h20, 8'h30, 8'd1,  4'd0,  1'b0},  // extreme weights, random features
    '{1'b1, 8'h08, 8'h40, 8'd20, 4'd7,  1'b0},
    '{1'b1, 8'h0c, 8'h70, 8'd6,  4'd15, 1'b0},
    '{1'b1, 8'h24, 8'h80, 8'd8,  4'd1,  1'b1}
};

// random signed bytes, then extreme words for the saturation rows
task automatic fill_memories();
    for (int a = 0; a < MEM_DEPTH; a++) begin
        fmem[MEM_AW'(a)] = {$urandom, $urandom};
        wmem[MEM_AW'(a)] = {$urandom, $urandom};
        imem[MEM_AW'(a)] = '0;                  // opcode 0 decodes as a no-op
    end
    for (int j = 0; j < NJOBS; j++) begin
        if (JOBS[j].sat) begin
            for (int i = 0; i < int'(JOBS[j].count); i++) begin
                fmem[MEM_AW'(int'(JOBS[j].f_src) + i)] = {TAPS{8'h7f}};
            end
            // even lanes push up, odd lanes push down
            for (int k = 0; k < TN; k++) begin
                wmem[MEM_AW'(int'(JOBS[j].w_src) + k)] =
                    (k % 2 == 0) ? {TAPS{8'h7f}} : {TAPS{8'h80}};
            end
        end
    end
endtask

`endif

// ==== sim/tb_dla.sv ====
`timescale 1ns/1ps

module tb_dla import dla_pkg::*; ();

    localparam int MEM_DEPTH      = 256;
    localparam int MEM_AW         = 8;
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int HOLD_CYCLES    = 120;    // window with credits withheld

    logic                       clk;
    logic                       i_reset;
    logic                       i_acc_enable;
    logic [BUS_WIDTH-1:0]       i_instr;
    logic [ADDR_WIDTH-1:0]      o_instr_addr;
    logic                       o_instr_rd_en;
    logic [BUS_WIDTH-1:0]       i_feature_data;
    logic [ADDR_WIDTH-1:0]      o_feature_addr;
    logic                       o_feature_rd_en;
    logic [BUS_WIDTH-1:0]       i_w_data;
    logic [ADDR_WIDTH-1:0]      o_w_addr;
    logic                       o_w_rd_en;
    logic [TN*RESULT_WIDTH-1:0] o_scaled_feature;
    logic                       o_result_valid;
    logic                       i_credit_return;
    logic                       o_done;

    logic [BUS_WIDTH-1:0] imem [MEM_DEPTH];
    logic [BUS_WIDTH-1:0] fmem [MEM_DEPTH];
    logic [BUS_WIDTH-1:0] wmem [MEM_DEPTH];

    // reads seen in the previous cycle
    logic                  instr_pend = 1'b0;
    logic                  feat_pend  = 1'b0;
    logic                  w_pend     = 1'b0;
    logic [ADDR_WIDTH-1:0] instr_pend_addr;
    logic [ADDR_WIDTH-1:0] feat_pend_addr;
    logic [ADDR_WIDTH-1:0] w_pend_addr;

    int results_seen     = 0;
    int credits_returned = 0;
    bit credits_open     = 1'b0;

    `include "tb_program.svh"

    logic [TN*RESULT_WIDTH-1:0] expected [NJOBS];

    dla_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // checks and failure exits
    //////////////////////////////////////////////////
    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic report_timeout(string what);
        $display("timed out while waiting for %s", what);
        fail_run();
    endtask

    task automatic check_quiet();
        check_value("o_result_valid", 64'(o_result_valid), 64'h0);
        check_value("o_done", 64'(o_done), 64'h0);
        check_value("o_instr_rd_en", 64'(o_instr_rd_en), 64'h0);
        check_value("o_feature_rd_en", 64'(o_feature_rd_en), 64'h0);
        check_value("o_w_rd_en", 64'(o_w_rd_en), 64'h0);
    endtask

    task automatic wait_for_results(int target, string what);
        int cycles;
        cycles = 0;
        while (results_seen < target) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_timeout(what);
        end
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (o_done !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_timeout("the done flag");
        end
    endtask

    //////////////////////////////////////////////////
    // program and reference model
    //////////////////////////////////////////////////
    function automatic logic [BUS_WIDTH-1:0] make_instr(opcode_e op, int count,
                                                        int src, int shift);
        logic [BUS_WIDTH-1:0] word;
        word = '0;
        word[OPC_LSB +: OPC_WIDTH]     = op;
        word[CNT_LSB +: CNT_WIDTH]     = CNT_WIDTH'(count);
        word[SRC_LSB +: ADDR_WIDTH]    = ADDR_WIDTH'(src);
        word[SHIFT_LSB +: SHIFT_WIDTH] = SHIFT_WIDTH'(shift);
        return word;
    endfunction

    // sum of signed byte products over count words, shifted, clipped to 16 bits
    function automatic logic [RESULT_WIDTH-1:0] lane_expected(int w_addr, int f_addr,
                                                             int count, int shift);
        longint sum;
        byte    f;
        byte    w;
        sum = 0;
        for (int i = 0; i < count; i++) begin
            for (int t = 0; t < TAPS; t++) begin
                f = fmem[MEM_AW'(f_addr + i)][t*FEATURE_WIDTH +: FEATURE_WIDTH];
                w = wmem[MEM_AW'(w_addr)][t*KERNEL_WIDTH +: KERNEL_WIDTH];
                sum += longint'(f) * longint'(w);
            end
        end
        sum = sum >>> shift;
        if (sum > 32767) return 16'h7fff;
        if (sum < -32768) return 16'h8000;
        return 16'(sum);
    endfunction

    task automatic build_program();
        int pc;
        int cur_w;
        pc    = 0;
        cur_w = 0;
        for (int j = 0; j < NJOBS; j++) begin
            if (JOBS[j].load_w) begin
                cur_w = int'(JOBS[j].w_src);
                imem[MEM_AW'(pc)] = make_instr(OP_LOAD_WEIGHT, 0, cur_w, 0);
                pc++;
            end
            imem[MEM_AW'(pc)] = make_instr(OP_COMPUTE, int'(JOBS[j].count),
                                           int'(JOBS[j].f_src), int'(JOBS[j].shift));
            pc++;
            for (int k = 0; k < TN; k++) begin   // lane k weights at cur_w + k
                expected[j][k*RESULT_WIDTH +: RESULT_WIDTH] =
                    lane_expected(cur_w + k, int'(JOBS[j].f_src),
                                  int'(JOBS[j].count), int'(JOBS[j].shift));
            end
        end
        imem[MEM_AW'(pc)] = make_instr(OP_END, 0, 0, 0);
    endtask

    //////////////////////////////////////////////////
    // memory models, credit return, result monitor
    //////////////////////////////////////////////////
    initial begin
        i_instr        = '0;
        i_feature_data = '0;
        i_w_data       = '0;
        forever begin
            @(posedge clk);
            #1;
            // answer the enables of the cycle that just ended
            if (instr_pend) i_instr = imem[MEM_AW'(instr_pend_addr)];
            if (feat_pend) i_feature_data = fmem[MEM_AW'(feat_pend_addr)];
            if (w_pend) i_w_data = wmem[MEM_AW'(w_pend_addr)];
            instr_pend      = o_instr_rd_en;
            instr_pend_addr = o_instr_addr;
            feat_pend       = o_feature_rd_en;
            feat_pend_addr  = o_feature_addr;
            w_pend          = o_w_rd_en;
            w_pend_addr     = o_w_addr;
        end
    end

    initial begin
        i_credit_return = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            i_credit_return = 1'b0;
            // only credits already spent go back
            if (credits_open && credits_returned < results_seen && ($urandom % 4) == 0) begin
                i_credit_return = 1'b1;
                credits_returned++;
            end
        end
    end

    always @(negedge clk) begin
        if (!i_reset && o_result_valid) begin
            if (results_seen >= NJOBS) begin
                $display("a result vector arrived after the last compute job");
                fail_run();
            end else begin
                check_value("o_done", 64'(o_done), 64'h0);      // done only after the last
                for (int k = 0; k < TN; k++) begin
                    check_value($sformatf("o_scaled_feature lane %0d job %0d", k, results_seen),
                                64'(o_scaled_feature[k*RESULT_WIDTH +: RESULT_WIDTH]),
                                64'(expected[results_seen][k*RESULT_WIDTH +: RESULT_WIDTH]));
                    if (JOBS[results_seen].sat) begin
                        check_value($sformatf("o_scaled_feature lane %0d limit", k),
                                    64'(o_scaled_feature[k*RESULT_WIDTH +: RESULT_WIDTH]),
                                    (k % 2 == 0) ? 64'h7fff : 64'h8000);
                    end
                end
                results_seen++;
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(86));
        i_reset      = 1'b1;
        i_acc_enable = 1'b0;
        fill_memories();
        build_program();
        repeat (8) @(posedge clk);
        #1;
        i_reset = 1'b0;

        for (int i = 0; i < 10; i++) begin     // idle until enabled
            @(posedge clk);
            #1;
            check_quiet();
        end

        i_acc_enable = 1'b1;
        @(posedge clk);
        #1;
        i_acc_enable = 1'b0;
        check_value("o_instr_rd_en", 64'(o_instr_rd_en), 64'h1);   // first fetch next cycle

        // reset credits only, the drain must hold the rest
        wait_for_results(RESULT_CREDITS, "the results covered by the reset credits");
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(posedge clk);
            #1;
            check_value("results with credits withheld", 64'(results_seen),
                        64'(RESULT_CREDITS));
        end

        credits_open = 1'b1;
        wait_for_done();
        check_value("results at o_done", 64'(results_seen), 64'(NJOBS));
        repeat (20) @(posedge clk);     // monitor still watches for a stray vector
        #1;

        $display("Finished with no errors");
        $finish;
    end

endmodule
